// File: vlog.f
source/router_pkg.sv
source/router_fifo.sv
source/router_sync.sv
source/router_fsm.sv
source/router_reg.sv
source/router_top.sv
testbench/router_asserts.sv
testbench/router_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module router_tb \
    -f vlog.f -o router_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/router_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulator exited with an error"; exit 1; }

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

// File: testbench/router_tb.sv
module router_tb
    import router_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT  = 400;   // Cycles per handshake wait
    localparam int DRAIN_LIMIT = 4000;  // Cycles to empty all ports

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    byte_t in_data = '0;
    logic  in_valid = 1'b0;
    logic  in_ready;
    byte_t out0_data, out1_data, out2_data;
    logic  out0_valid, out1_valid, out2_valid;
    logic  out0_last, out1_last, out2_last;
    logic  out0_ready = 1'b0;
    logic  out1_ready = 1'b0;
    logic  out2_ready = 1'b0;
    logic  err;

    logic [2:0]  hold = '0;       // Forces a reader off
    logic [31:0] rng_state = 32'd36;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    string       cur_test = "reset_state";
    byte_t       exp_data [3][$];  // Reference model, one queue per port
    logic        exp_last [3][$];
    byte_t       out_data_v [3];
    logic [2:0]  out_valid_v;
    logic [2:0]  out_last_v;
    logic [2:0]  out_ready_v;

    assign out_data_v[0] = out0_data;
    assign out_data_v[1] = out1_data;
    assign out_data_v[2] = out2_data;
    assign out_valid_v   = {out2_valid, out1_valid, out0_valid};
    assign out_last_v    = {out2_last, out1_last, out0_last};
    assign out_ready_v   = {out2_ready, out1_ready, out0_ready};

    router_top #(.FIFO_DEPTH(FIFO_DEPTH_DEF), .TIMEOUT_CYCLES(TIMEOUT_DEF)) dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic check_byte(string name, byte_t exp, byte_t act);
        checks++;
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_last(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            $display("[FAIL] %s last: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_err(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            $display("[FAIL] %s err: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_quiet(string when);
        checks++;
        if (in_ready !== 1'b0 || out_valid_v !== 3'b000 || err !== 1'b0) begin
            $display("Outputs not idle %s: in_ready=%b valid=%b err=%b",
                     when, in_ready, out_valid_v, err);
            errors++;
        end
    endtask

    task automatic abort_run(string what);
        $display("Timeout: %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic finish_test(string name, int errors_before);
        tests++;
        $display("Test %s done, %0d new errors", name, errors - errors_before);
    endtask

    // Readers, each high about three cycles in four unless held off
    always @(posedge clk) begin
        logic [31:0] r;
        r = next_rand();
        out0_ready <= !hold[0] && (r[1:0] != 2'b00);
        out1_ready <= !hold[1] && (r[3:2] != 2'b00);
        out2_ready <= !hold[2] && (r[5:4] != 2'b00);
    end

    // Output monitor, a pop happens on the next rising edge
    always @(negedge clk) begin
        for (int p = 0; p < 3; p++) begin
            if (!rst && out_valid_v[p] && out_ready_v[p]) begin
                if (exp_data[p].size() == 0) begin
                    $display("Unexpected byte %h on port %0d", out_data_v[p], p);
                    errors++;
                end else begin
                    check_byte($sformatf("%s port%0d", cur_test, p),
                               exp_data[p].pop_front(), out_data_v[p]);
                    check_last($sformatf("%s port%0d", cur_test, p),
                               exp_last[p].pop_front(), out_last_v[p]);
                end
            end
        end
    end

    // Header, payload, parity; keep=0 means the packet is expected to vanish
    task automatic send_packet(string name, port_t port, len_t len, logic bad, logic keep,
                               output int stalls);
        byte_t pkt[$];
        byte_t par;
        int    n;
        pkt.push_back({len, port});
        par = {len, port};
        for (int i = 0; i < int'(len); i++) begin
            pkt.push_back(byte_t'(next_rand()));
            par ^= pkt[i + 1];
        end
        if (bad) begin
            par ^= byte_t'(next_rand() | 32'd1);  // Never zero
        end
        pkt.push_back(par);
        if (keep && port != PORT_DROP) begin
            foreach (pkt[i]) begin
                exp_data[port].push_back(pkt[i]);
                exp_last[port].push_back(i == pkt.size() - 1);
            end
        end
        stalls = 0;
        @(posedge clk);
        foreach (pkt[i]) begin
            in_data  <= pkt[i];
            in_valid <= 1'b1;
            n = 0;
            @(negedge clk);
            while (!in_ready) begin
                stalls++;
                n++;
                if (n > WAIT_LIMIT) begin
                    abort_run($sformatf("%s byte %0d never accepted", name, i));
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
        @(negedge clk);
        check_err(name, bad && keep && port != PORT_DROP, err);
    endtask

    task automatic drain(string what);
        int n;
        n = 0;
        while (exp_data[0].size() + exp_data[1].size() + exp_data[2].size() != 0) begin
            n++;
            if (n > DRAIN_LIMIT) begin
                abort_run($sformatf("%s, expected bytes never came out", what));
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int          stalls;
        int          e0;
        logic [31:0] r;
        e0 = errors;
        repeat (10) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_quiet("just after reset");  // Ready rises one cycle later
        finish_test(cur_test, e0);

        e0 = errors;
        cur_test = "routing_parity";
        for (int k = 0; k < 40; k++) begin
            r = next_rand();
            send_packet($sformatf("pkt%0d", k), port_t'(r % 3), len_t'(r[13:8]),
                        r[19:18] == 2'b00, 1'b1, stalls);
        end
        drain("random packets");
        finish_test(cur_test, e0);

        e0 = errors;
        cur_test = "drop";
        send_packet("drop", PORT_DROP, 6'd20, 1'b1, 1'b1, stalls);  // Bad parity, still no err
        if (stalls != 0) begin
            $display("in_ready went low %0d times during a dropped packet", stalls);
            errors++;
        end
        send_packet("after_drop", 2'd1, 6'd5, 1'b0, 1'b1, stalls);
        drain("packet after drop");
        finish_test(cur_test, e0);

        e0 = errors;
        cur_test = "backpressure";
        @(posedge clk);
        hold[0] <= 1'b1;
        fork
            begin
                repeat (20) @(posedge clk);
                hold[0] <= 1'b0;
            end
            send_packet("backpressure", 2'd0, 6'd38, 1'b0, 1'b1, stalls);
        join
        if (stalls == 0) begin
            $display("in_ready never dropped while port 0 was full");
            errors++;
        end
        drain("back-pressure packet");
        finish_test(cur_test, e0);

        e0 = errors;
        cur_test = "watchdog_flush";
        @(posedge clk);
        hold[2] <= 1'b1;
        send_packet("flush", 2'd2, 6'd60, 1'b0, 1'b0, stalls);
        @(negedge clk);
        if (out2_valid) begin
            $display("Port 2 still holds bytes after the watchdog flush");
            errors++;
        end
        @(posedge clk);
        hold[2] <= 1'b0;
        send_packet("after_flush", 2'd2, 6'd12, 1'b0, 1'b1, stalls);
        drain("packet after flush");
        finish_test(cur_test, e0);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/router_asserts.sv
module router_asserts (
    input logic clk,
    input logic rst,
    input logic in_ready,
    input logic err,
    input logic wr_en0,
    input logic wr_en1,
    input logic wr_en2,
    input logic full0,
    input logic full1,
    input logic full2,
    input logic out0_valid,
    input logic out1_valid,
    input logic out2_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] full_v;
    logic [2:0] valid_v;
    logic [2:0] wr_v;

    assign full_v  = {full2, full1, full0};
    assign valid_v = {out2_valid, out1_valid, out0_valid};
    assign wr_v    = {wr_en2, wr_en1, wr_en0};

    a_ready_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !in_ready)
        else $error("in_ready high during reset");

    a_err_one_cycle: assert property (@(posedge clk) disable iff (rst) err |=> !err)
        else $error("err high for two cycles");

    for (genvar n = 0; n < 3; n++) begin : g_port
        // A full FIFO has loaded its output stage
        a_full_valid: assert property (@(posedge clk) disable iff (rst) full_v[n] |-> valid_v[n])
            else $error("FIFO %0d full with no valid output", n);
        a_no_write_full: assert property (@(posedge clk) disable iff (rst) !(wr_v[n] && full_v[n]))
            else $error("Write into full FIFO %0d", n);
    end

endmodule

bind router_top router_asserts asserts_i (.*);

// File: source/router_top.sv
module router_top
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH     = FIFO_DEPTH_DEF,  // Power of two
    parameter int TIMEOUT_CYCLES = TIMEOUT_DEF
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t in_data,
    input  logic  in_valid,
    output logic  in_ready,
    output byte_t out0_data,
    output logic  out0_valid,
    output logic  out0_last,
    input  logic  out0_ready,
    output byte_t out1_data,
    output logic  out1_valid,
    output logic  out1_last,
    input  logic  out1_ready,
    output byte_t out2_data,
    output logic  out2_valid,
    output logic  out2_last,
    input  logic  out2_ready,
    output logic  err
);
    logic  hdr_load;
    logic  byte_load;
    logic  parity_load;
    logic  drop_active;
    logic  dest_full;
    logic  flush_hit;
    port_t dest;
    logic  wr_en0, wr_en1, wr_en2;
    logic  full0, full1, full2;
    logic  soft_rst0, soft_rst1, soft_rst2;

    router_fsm fsm_i (
        .clk, .rst, .in_valid, .in_ready, .in_data, .dest_full, .flush_hit,
        .hdr_load, .byte_load, .parity_load, .drop_active
    );

    router_reg reg_i (
        .clk, .rst, .in_data, .hdr_load, .byte_load, .parity_load,
        .dest, .len(), .err
    );

    router_sync #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) sync_i (
        .clk, .rst, .dest, .byte_load, .drop_active,
        .full0, .full1, .full2,
        .out0_valid, .out1_valid, .out2_valid,
        .out0_ready, .out1_ready, .out2_ready,
        .wr_en0, .wr_en1, .wr_en2, .dest_full,
        .soft_rst0, .soft_rst1, .soft_rst2, .flush_hit
    );

    router_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0_i (
        .clk, .rst, .soft_rst(soft_rst0), .wr_en(wr_en0), .first(hdr_load), .din(in_data),
        .full(full0), .dout(out0_data), .valid(out0_valid), .last(out0_last),
        .ready(out0_ready)
    );

    router_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo1_i (
        .clk, .rst, .soft_rst(soft_rst1), .wr_en(wr_en1), .first(hdr_load), .din(in_data),
        .full(full1), .dout(out1_data), .valid(out1_valid), .last(out1_last),
        .ready(out1_ready)
    );

    router_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo2_i (
        .clk, .rst, .soft_rst(soft_rst2), .wr_en(wr_en2), .first(hdr_load), .din(in_data),
        .full(full2), .dout(out2_data), .valid(out2_valid), .last(out2_last),
        .ready(out2_ready)
    );

endmodule

// File: source/router_reg.sv
module router_reg
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t in_data,
    input  logic  hdr_load,
    input  logic  byte_load,
    input  logic  parity_load,
    output port_t dest,
    output len_t  len,
    output logic  err
);
    port_t dest_q;     // Destination of the current packet
    len_t  len_q;      // Payload length of the current packet
    byte_t parity_q;   // Running XOR of header and payload
    logic  err_q;

    // Header fields are passed straight through while the header is on the bus
    assign dest = hdr_load ? port_t'(in_data[1:0]) : dest_q;
    assign len  = hdr_load ? len_t'(in_data[7:2]) : len_q;
    assign err  = err_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            dest_q <= '0;
            len_q  <= '0;
        end else if (hdr_load) begin
            dest_q <= in_data[1:0];
            len_q  <= in_data[7:2];
        end
    end

    // Header seeds the XOR, payload bytes fold in, the parity byte does not
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            parity_q <= in_data;
        end else if (byte_load && !parity_load) begin
            parity_q <= parity_q ^ in_data;
        end
    end

    // Single cycle pulse on a parity mismatch
    always_ff @(posedge clk) begin
        if (rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= parity_load && (in_data != parity_q);
        end
    end

endmodule

// File: source/router_fsm.sv
module router_fsm
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    output logic  in_ready,
    input  byte_t in_data,
    input  logic  dest_full,
    input  logic  flush_hit,
    output logic  hdr_load,
    output logic  byte_load,
    output logic  parity_load,
    output logic  drop_active
);
    route_state_t state;
    route_state_t state_nxt;
    logic [6:0]   remain;      // Bytes left in the payload or drop phase
    logic [6:0]   remain_nxt;
    logic         active;      // Low until the cycle after reset
    logic         xfer;
    len_t         hdr_len;
    port_t        hdr_port;

    assign hdr_len  = in_data[7:2];
    assign hdr_port = in_data[1:0];
    assign xfer     = in_valid && in_ready;

    // In st_idle the header's own FIFO is checked so a header is never lost
    always_comb begin
        case (state)
            st_idle:               in_ready = active && !dest_full;
            st_payload, st_parity: in_ready = !dest_full;
            default:               in_ready = 1'b1;  // Drop swallows everything
        endcase
    end

    // Header on the bus, the register block follows it until it transfers
    assign hdr_load    = active && in_valid && (state == st_idle);
    assign parity_load = xfer && (state == st_parity);
    assign drop_active = (state == st_drop);

    always_comb begin
        case (state)
            st_idle:               byte_load = xfer && (hdr_port != PORT_DROP);
            st_payload, st_parity: byte_load = xfer;
            default:               byte_load = 1'b0;
        endcase
    end

    always_comb begin
        state_nxt  = state;
        remain_nxt = remain;
        case (state)
            st_idle: begin
                if (xfer) begin
                    if (hdr_port == PORT_DROP || flush_hit) begin
                        state_nxt  = st_drop;
                        remain_nxt = {1'b0, hdr_len} + 7'd1;  // Payload plus parity
                    end else if (hdr_len == '0) begin
                        state_nxt = st_parity;
                    end else begin
                        state_nxt  = st_payload;
                        remain_nxt = {1'b0, hdr_len};
                    end
                end
            end
            st_payload: begin
                if (flush_hit) begin
                    // Earlier bytes are gone, discard the rest
                    state_nxt  = st_drop;
                    remain_nxt = xfer ? remain : remain + 7'd1;
                end else if (xfer) begin
                    remain_nxt = remain - 7'd1;
                    if (remain == 7'd1) begin
                        state_nxt = st_parity;
                    end
                end
            end
            st_parity: begin
                if (xfer) begin
                    state_nxt = st_idle;
                end else if (flush_hit) begin
                    state_nxt  = st_drop;
                    remain_nxt = 7'd1;
                end
            end
            default: begin
                if (xfer) begin
                    remain_nxt = remain - 7'd1;
                    if (remain == 7'd1) begin
                        state_nxt = st_idle;  // Parity byte discarded
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            remain <= '0;
            active <= 1'b0;
        end else begin
            state  <= state_nxt;
            remain <= remain_nxt;
            active <= 1'b1;
        end
    end

endmodule

// File: source/router_sync.sv
module router_sync
    import router_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = TIMEOUT_DEF
) (
    input  logic  clk,
    input  logic  rst,
    input  port_t dest,
    input  logic  byte_load,
    input  logic  drop_active,
    input  logic  full0,
    input  logic  full1,
    input  logic  full2,
    input  logic  out0_valid,
    input  logic  out1_valid,
    input  logic  out2_valid,
    input  logic  out0_ready,
    input  logic  out1_ready,
    input  logic  out2_ready,
    output logic  wr_en0,
    output logic  wr_en1,
    output logic  wr_en2,
    output logic  dest_full,
    output logic  soft_rst0,
    output logic  soft_rst1,
    output logic  soft_rst2,
    output logic  flush_hit
);
    localparam int CW = $clog2(TIMEOUT_CYCLES + 1);

    logic [2:0]    full_v;
    logic [2:0]    valid_v;
    logic [2:0]    ready_v;
    logic [2:0]    wr_v;
    logic [2:0]    srst_v;
    logic [CW-1:0] stall_cnt [3];  // One watchdog per output port

    assign full_v  = {full2, full1, full0};
    assign valid_v = {out2_valid, out1_valid, out0_valid};
    assign ready_v = {out2_ready, out1_ready, out0_ready};

    assign {wr_en2, wr_en1, wr_en0}          = wr_v;
    assign {soft_rst2, soft_rst1, soft_rst0} = srst_v;

    // Destination demux, port 3 reaches no FIFO
    always_comb begin
        wr_v      = '0;
        dest_full = 1'b0;
        flush_hit = 1'b0;
        if (dest != PORT_DROP) begin
            wr_v[dest] = byte_load;
            dest_full  = full_v[dest];
            flush_hit  = srst_v[dest] && !drop_active;  // Controller qualifies it
        end
    end

    for (genvar n = 0; n < 3; n++) begin : g_watchdog
        // Counts stalled cycles, restarts on a pop or an empty output
        always_ff @(posedge clk) begin
            if (rst || srst_v[n] || !valid_v[n] || ready_v[n]) begin
                stall_cnt[n] <= '0;
            end else if (stall_cnt[n] != CW'(TIMEOUT_CYCLES)) begin
                stall_cnt[n] <= stall_cnt[n] + 1'b1;
            end
        end

        assign srst_v[n] = (stall_cnt[n] == CW'(TIMEOUT_CYCLES));  // One cycle wide
    end

endmodule

// File: source/router_fifo.sv
module router_fifo
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  soft_rst,
    input  logic  wr_en,
    input  logic  first,
    input  byte_t din,
    output logic  full,
    output byte_t dout,
    output logic  valid,
    output logic  last,
    input  logic  ready
);
    localparam int AW = $clog2(FIFO_DEPTH);

    fifo_word_t    mem [FIFO_DEPTH];  // Storage, flag in bit 8
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;             // Entries held in mem
    fifo_word_t    out_word;          // Output stage
    logic          out_valid;
    logic [6:0]    remain;            // Bytes of the packet still to pop
    logic          do_write;
    logic          do_load;
    logic          pop;

    assign full     = (count == (AW + 1)'(FIFO_DEPTH));
    assign do_write = wr_en && !full && !soft_rst;
    assign pop      = out_valid && ready;
    // Refill the output stage when it is free or being popped
    assign do_load  = (count != '0) && (!out_valid || pop);

    assign dout  = out_word[7:0];
    assign valid = out_valid;
    assign last  = out_valid && (remain == 7'd1);  // Parity byte on the output

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= {first, din};
        end
    end

    always_ff @(posedge clk) begin
        if (do_load) begin
            out_word <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || soft_rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth
            end
            if (do_load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_load})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (do_load) begin
                out_valid <= 1'b1;
            end else if (pop) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Packet boundary tracking on the read side
    always_ff @(posedge clk) begin
        if (rst || soft_rst) begin
            remain <= '0;
        end else if (pop) begin
            if (out_word[8]) begin
                remain <= {1'b0, out_word[7:2]} + 7'd1;  // Payload plus parity
            end else if (remain != '0) begin
                remain <= remain - 1'b1;
            end
        end
    end

endmodule

// File: source/router_pkg.sv
package router_pkg;

    // One byte on the packet stream
    typedef logic [7:0] byte_t;

    // Payload length field, header bits 7:2
    typedef logic [5:0] len_t;

    // Destination field, header bits 1:0 (3 means drop)
    typedef logic [1:0] port_t;

    // FIFO entry, first-byte flag on top of the data byte
    typedef logic [8:0] fifo_word_t;

    // Packet controller states
    typedef enum logic [1:0] {
        st_idle,     // Waiting for a header
        st_payload,  // Passing payload bytes
        st_parity,   // Passing the parity byte
        st_drop      // Discarding the rest of a packet
    } route_state_t;

    // Destination code that drops the whole packet
    localparam port_t PORT_DROP = 2'd3;

    // Defaults for the top level parameters
    localparam int FIFO_DEPTH_DEF = 16;  // Entries per output FIFO
    localparam int TIMEOUT_DEF    = 30;  // Stall cycles before a flush

endpackage
